// File: src/nic_pkg.sv
/*
 * Shared constants, CSR map and bus types of the NIC slice.
 * All CSR addresses count 32-bit words, so 64-bit registers sit on even addresses.
 * The flow count and queue depth are fixed here; changing them resizes every block.
 */

package nic_pkg;

    // ====================
    // Sizing
    // ====================
    localparam logic [7:0] nic_id = 8'd5;

    // 2**3 = 8 flows
    localparam int lmax_flows = 3;
    localparam int max_flows  = 2 ** lmax_flows;

    // 2**3 = 8 queue entries
    localparam int fifo_ldepth = 3;
    localparam int fifo_depth  = 2 ** fifo_ldepth;

    typedef logic [lmax_flows-1:0] flow_id_t;
    typedef logic [31:0]           payload_t;
    typedef logic [15:0]           seq_t;
    typedef logic [15:0]           mmio_addr_t;
    typedef logic [63:0]           mmio_data_t;

    // ====================
    // CSR address map
    // ====================
    localparam mmio_addr_t addr_nic_start   = 16'd4;
    localparam mmio_addr_t addr_num_flows   = 16'd6;
    localparam mmio_addr_t addr_nic_status  = 16'd10;
    localparam mmio_addr_t addr_get_pck_cnt = 16'd14;
    localparam mmio_addr_t addr_pck_cnt     = 16'd16;
    localparam mmio_addr_t addr_ccip_mode   = 16'd18;

    typedef enum logic [1:0] {
        mode_mmio,
        mode_polling,
        mode_dma,
        mode_queue_polling
    } ccip_mode_e;

    // Only the queue polling transport exists in this build
    localparam ccip_mode_e active_mode = mode_queue_polling;

    // Counter selector whose other values read back as zero
    typedef enum logic [7:0] {
        cnt_rpc_in   = 8'd0,
        cnt_rpc_drop = 8'd1,
        cnt_net_tx   = 8'd2
    } pck_cnt_sel_e;

    // ====================
    // Packed bundles
    // ====================
    typedef struct packed {
        flow_id_t flow_id;
        payload_t payload;
    } rpc_req_t;

    typedef struct packed {
        flow_id_t flow_id;
        seq_t     seq;
        payload_t payload;
    } net_packet_t;

    typedef struct packed {
        logic       rd_valid;
        logic       wr_valid;
        mmio_addr_t addr;
        mmio_data_t wdata;
        logic [8:0] tid;
    } mmio_req_t;

    typedef struct packed {
        logic       rd_valid;
        logic [8:0] tid;
        mmio_data_t rdata;
    } mmio_rsp_t;

    typedef struct packed {
        logic [7:0] nic_id;
        logic       running;
        logic       fifo_full;
    } nic_status_t;

    // One-cycle strobes feeding the packet counters
    typedef struct packed {
        logic accepted;
        logic dropped;
        logic sent;
    } rpc_event_t;

endpackage

// File: src/nic_csr.sv
/*
 * MMIO register block with start bit, flow count and counter selector.
 * Reads answer one cycle later; unknown addresses return zero.
 * Writes to read-only addresses are ignored. Counters are 64 bit and wrap.
 */

module nic_csr (
    input  logic                 ccip_clk,
    input  logic                 reset,
    input  nic_pkg::mmio_req_t   mmio,
    output nic_pkg::mmio_rsp_t   mmio_rsp,
    input  nic_pkg::rpc_event_t  events,
    input  logic                 fifo_full,
    output logic                 nic_start,
    output nic_pkg::flow_id_t    num_flows
);

    nic_pkg::pck_cnt_sel_e cnt_sel;

    logic [63:0] cnt_in;
    logic [63:0] cnt_drop;
    logic [63:0] cnt_tx;

    nic_pkg::nic_status_t status;
    nic_pkg::mmio_data_t  pck_cnt;
    nic_pkg::mmio_data_t  rd_data;

    // ====================
    // Write registers
    // ====================
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            nic_start <= 1'b0;
            // All ones means the full flow range
            num_flows <= '1;
            cnt_sel   <= nic_pkg::cnt_rpc_in;
        end else if (mmio.wr_valid) begin
            case (mmio.addr)
                nic_pkg::addr_nic_start: begin
                    nic_start <= mmio.wdata[0];
                end
                nic_pkg::addr_num_flows: begin
                    // Stored as count minus one so that zero wraps to the maximum
                    num_flows <= mmio.wdata[nic_pkg::lmax_flows-1:0] - 1'b1;
                end
                nic_pkg::addr_get_pck_cnt: begin
                    cnt_sel <= nic_pkg::pck_cnt_sel_e'(mmio.wdata[7:0]);
                end
                default: begin
                end
            endcase
        end
    end

    // ====================
    // Packet counters
    // ====================
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            cnt_in   <= '0;
            cnt_drop <= '0;
            cnt_tx   <= '0;
        end else begin
            if (events.accepted) begin
                cnt_in <= cnt_in + 64'd1;
            end
            if (events.dropped) begin
                cnt_drop <= cnt_drop + 64'd1;
            end
            if (events.sent) begin
                cnt_tx <= cnt_tx + 64'd1;
            end
        end
    end

    // ====================
    // Read path
    // ====================
    always_comb begin
        status.nic_id    = nic_pkg::nic_id;
        status.running   = nic_start;
        status.fifo_full = fifo_full;

        case (cnt_sel)
            nic_pkg::cnt_rpc_in:   pck_cnt = cnt_in;
            nic_pkg::cnt_rpc_drop: pck_cnt = cnt_drop;
            nic_pkg::cnt_net_tx:   pck_cnt = cnt_tx;
            default:               pck_cnt = '0;
        endcase

        case (mmio.addr)
            nic_pkg::addr_nic_status: rd_data = nic_pkg::mmio_data_t'(status);
            nic_pkg::addr_pck_cnt:    rd_data = pck_cnt;
            nic_pkg::addr_ccip_mode:  rd_data = nic_pkg::mmio_data_t'(nic_pkg::active_mode);
            default:                  rd_data = '0;
        endcase
    end

    // Read response registered one cycle after the request
    always_ff @(posedge ccip_clk) begin
        mmio_rsp.tid   <= mmio.tid;
        mmio_rsp.rdata <= rd_data;
        if (reset) begin
            mmio_rsp.rd_valid <= 1'b0;
        end else begin
            mmio_rsp.rd_valid <= mmio.rd_valid;
        end
    end

endmodule

// File: src/rpc_ingress.sv
/*
 * Four-phase receiver for host RPC requests.
 * rpc_in must stay stable while rpc_req is high and rpc_ack is low.
 * A valid request waits without ack while the queue is full.
 */

module rpc_ingress (
    input  logic                ccip_clk,
    input  logic                reset,
    input  logic                rpc_req,
    input  nic_pkg::rpc_req_t   rpc_in,
    output logic                rpc_ack,
    input  nic_pkg::flow_id_t   num_flows,
    input  logic                full,
    output logic                push,
    output nic_pkg::rpc_req_t   push_data,
    output logic                accepted,
    output logic                dropped
);

    typedef enum logic [1:0] {
        idle,
        acked,
        wait_low
    } ingress_state_e;

    ingress_state_e state;
    ingress_state_e state_next;

    logic flow_ok;
    logic take;

    // num_flows holds the flow count minus one
    assign flow_ok = (rpc_in.flow_id <= num_flows);

    // A request is taken once, in the idle state only
    assign take     = (state == idle) && rpc_req && (!flow_ok || !full);
    assign push     = take && flow_ok;
    assign dropped  = take && !flow_ok;
    assign accepted = push;

    assign push_data = rpc_in;

    assign rpc_ack = (state == acked);

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (take) begin
                    state_next = acked;
                end
            end
            acked: begin
                if (!rpc_req) begin
                    state_next = wait_low;
                end
            end
            // One recovery cycle so the host sees ack low before the next request
            wait_low: begin
                state_next = idle;
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

endmodule

// File: src/rpc_fifo.sv
/*
 * Single-clock request queue of 2**fifo_ldepth entries.
 * head is valid whenever empty is low; pop and push act at the clock edge.
 * A push while full or a pop while empty is ignored.
 */

module rpc_fifo (
    input  logic               ccip_clk,
    input  logic               reset,
    input  logic               push,
    input  nic_pkg::rpc_req_t  push_data,
    input  logic               pop,
    output nic_pkg::rpc_req_t  head,
    output logic               empty,
    output logic               full
);

    nic_pkg::rpc_req_t mem [nic_pkg::fifo_depth];

    // Extra top bit tells a full queue from an empty one
    logic [nic_pkg::fifo_ldepth:0] wr_ptr;
    logic [nic_pkg::fifo_ldepth:0] rd_ptr;

    logic do_push;
    logic do_pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[nic_pkg::fifo_ldepth] != rd_ptr[nic_pkg::fifo_ldepth]) &&
                   (wr_ptr[nic_pkg::fifo_ldepth-1:0] == rd_ptr[nic_pkg::fifo_ldepth-1:0]);

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign head = mem[rd_ptr[nic_pkg::fifo_ldepth-1:0]];

    always_ff @(posedge ccip_clk) begin
        if (do_push) begin
            mem[wr_ptr[nic_pkg::fifo_ldepth-1:0]] <= push_data;
        end
    end

    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// File: src/net_tx_builder.sv
/*
 * Drains the request queue while nic_start is high, one entry per cycle.
 * Each packet carries a per-flow sequence number that wraps at 2**16.
 * The network side has no back-pressure, so packets leave as they are built.
 */

module net_tx_builder (
    input  logic                  ccip_clk,
    input  logic                  reset,
    input  logic                  nic_start,
    input  logic                  empty,
    input  nic_pkg::rpc_req_t     head,
    output logic                  pop,
    output nic_pkg::net_packet_t  net_tx,
    output logic                  net_tx_valid,
    output logic                  sent
);

    // Next sequence number of every flow
    nic_pkg::seq_t seq_cnt [nic_pkg::max_flows];

    assign pop = nic_start && !empty;

    // ====================
    // Sequence counters
    // ====================
    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            for (int i = 0; i < nic_pkg::max_flows; i++) begin
                seq_cnt[i] <= '0;
            end
        end else if (pop) begin
            seq_cnt[head.flow_id] <= seq_cnt[head.flow_id] + 1'b1;
        end
    end

    // ====================
    // Packet register
    // ====================
    always_ff @(posedge ccip_clk) begin
        if (pop) begin
            net_tx.flow_id <= head.flow_id;
            net_tx.seq     <= seq_cnt[head.flow_id];
            net_tx.payload <= head.payload;
        end
    end

    always_ff @(posedge ccip_clk) begin
        if (reset) begin
            net_tx_valid <= 1'b0;
        end else begin
            net_tx_valid <= pop;
        end
    end

    // Counted when the packet is on the wire
    assign sent = net_tx_valid;

endmodule

// File: src/nic.sv
/*
 * NIC top level on a single ccip_clk domain.
 * Host requests enter through a four-phase port, network packets leave valid-only.
 * Packets only leave while the start bit is set.
 */

module nic (
    input  logic                  ccip_clk,
    input  logic                  reset,
    input  nic_pkg::mmio_req_t    mmio,
    output nic_pkg::mmio_rsp_t    mmio_rsp,
    input  logic                  rpc_req,
    input  nic_pkg::rpc_req_t     rpc_in,
    output logic                  rpc_ack,
    output nic_pkg::net_packet_t  net_tx,
    output logic                  net_tx_valid
);

    logic                 nic_start;
    nic_pkg::flow_id_t    num_flows;
    nic_pkg::rpc_event_t  events;

    logic                 push;
    nic_pkg::rpc_req_t    push_data;
    logic                 pop;
    nic_pkg::rpc_req_t    head;
    logic                 empty;
    logic                 full;

    // ====================
    // Control and status
    // ====================
    nic_csr u_csr (
        .ccip_clk  (ccip_clk),
        .reset     (reset),
        .mmio      (mmio),
        .mmio_rsp  (mmio_rsp),
        .events    (events),
        .fifo_full (full),
        .nic_start (nic_start),
        .num_flows (num_flows)
    );

    // ====================
    // Request datapath
    // ====================
    rpc_ingress u_ingress (
        .ccip_clk  (ccip_clk),
        .reset     (reset),
        .rpc_req   (rpc_req),
        .rpc_in    (rpc_in),
        .rpc_ack   (rpc_ack),
        .num_flows (num_flows),
        .full      (full),
        .push      (push),
        .push_data (push_data),
        .accepted  (events.accepted),
        .dropped   (events.dropped)
    );

    rpc_fifo u_fifo (
        .ccip_clk  (ccip_clk),
        .reset     (reset),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .head      (head),
        .empty     (empty),
        .full      (full)
    );

    net_tx_builder u_tx (
        .ccip_clk     (ccip_clk),
        .reset        (reset),
        .nic_start    (nic_start),
        .empty        (empty),
        .head         (head),
        .pop          (pop),
        .net_tx       (net_tx),
        .net_tx_valid (net_tx_valid),
        .sent         (events.sent)
    );

endmodule

// File: tb/nic_tb.sv
/*
 * Random-stimulus testbench for the NIC slice, with a reference model of the packet stream.
 * Inputs change on the falling edge and outputs are sampled on the falling edge.
 * Each handshake, read and drain wait gives up after a fixed number of cycles.
 */

module nic_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                 ccip_clk;
    logic                 reset;
    nic_pkg::mmio_req_t   mmio;
    nic_pkg::mmio_rsp_t   mmio_rsp;
    logic                 rpc_req;
    nic_pkg::rpc_req_t    rpc_in;
    logic                 rpc_ack;
    nic_pkg::net_packet_t net_tx;
    logic                 net_tx_valid;

    integer seed;
    int     errors;
    int     tests_run;
    int     tests_failed;
    int     test_start_errors;

    // ====================
    // Reference model
    // ====================
    nic_pkg::net_packet_t exp_q[$];
    logic [15:0]          model_seq [8];
    int                   model_flows;
    logic [63:0]          model_accepted;
    logic [63:0]          model_dropped;
    logic [63:0]          model_sent;

    nic dut (
        .ccip_clk     (ccip_clk),
        .reset        (reset),
        .mmio         (mmio),
        .mmio_rsp     (mmio_rsp),
        .rpc_req      (rpc_req),
        .rpc_in       (rpc_in),
        .rpc_ack      (rpc_ack),
        .net_tx       (net_tx),
        .net_tx_valid (net_tx_valid)
    );

    always #5 ccip_clk = ~ccip_clk;

    task automatic report_failure(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        errors++;
    endtask

    task automatic compare_value(input string name, input logic [63:0] exp,
                                 input logic [63:0] got);
        assert (got === exp) else begin
            $display("MISMATCH at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
            errors++;
        end
    endtask

    // Packet monitor checks each valid cycle against the next expected packet
    always @(negedge ccip_clk) begin
        nic_pkg::net_packet_t exp_pkt;
        if (!reset && net_tx_valid) begin
            assert (exp_q.size() != 0) else report_failure("packet emitted with none expected");
            if (exp_q.size() != 0) begin
                exp_pkt = exp_q.pop_front();
                compare_value("net_tx.flow_id", 64'(exp_pkt.flow_id), 64'(net_tx.flow_id));
                compare_value("net_tx.seq", 64'(exp_pkt.seq), 64'(net_tx.seq));
                compare_value("net_tx.payload", 64'(exp_pkt.payload), 64'(net_tx.payload));
                model_sent = model_sent + 64'd1;
            end
        end
    end

    // ====================
    // CSR access
    // ====================
    task automatic csr_write(input logic [15:0] addr, input logic [63:0] data);
        @(negedge ccip_clk);
        mmio.wr_valid = 1'b1;
        mmio.addr     = addr;
        mmio.wdata    = data;
        @(negedge ccip_clk);
        mmio.wr_valid = 1'b0;
    endtask

    task automatic csr_read(input logic [15:0] addr, output logic [63:0] data);
        logic [8:0] tid;
        bit         got;
        int         i;
        tid = 9'($random(seed));
        @(negedge ccip_clk);
        mmio.rd_valid = 1'b1;
        mmio.addr     = addr;
        mmio.tid      = tid;
        @(negedge ccip_clk);
        mmio.rd_valid = 1'b0;
        got = mmio_rsp.rd_valid;
        i = 0;
        while (!got && i < 4) begin
            @(negedge ccip_clk);
            got = mmio_rsp.rd_valid;
            i++;
        end
        assert (got) else report_failure("no read response from the CSR block");
        assert (!got || i == 0) else report_failure("read response came later than one cycle");
        data = '0;
        if (got) begin
            compare_value("mmio_rsp.tid", 64'(tid), 64'(mmio_rsp.tid));
            data = mmio_rsp.rdata;
            @(negedge ccip_clk);
            assert (!mmio_rsp.rd_valid)
                else report_failure("read response stayed valid for more than one cycle");
        end
    endtask

    // ====================
    // Host request port
    // ====================
    task automatic record_request(input logic [2:0] flow, input logic [31:0] payload);
        nic_pkg::net_packet_t pkt;
        if (int'(flow) < model_flows) begin
            pkt.flow_id = flow;
            pkt.seq     = model_seq[flow];
            pkt.payload = payload;
            exp_q.push_back(pkt);
            model_seq[flow] = model_seq[flow] + 16'd1;
            model_accepted  = model_accepted + 64'd1;
        end else begin
            model_dropped = model_dropped + 64'd1;
        end
    endtask

    task automatic wait_for_ack(input int limit, output bit got, output int cycles);
        got = 1'b0;
        cycles = 0;
        while (!got && cycles < limit) begin
            @(negedge ccip_clk);
            got = rpc_ack;
            cycles++;
        end
    endtask

    task automatic release_request();
        int i;
        rpc_req = 1'b0;
        i = 0;
        while (rpc_ack && i < 10) begin
            @(negedge ccip_clk);
            i++;
        end
        assert (!rpc_ack) else report_failure("rpc_ack stayed high after rpc_req went low");
    endtask

    task automatic raise_request(input logic [2:0] flow, input logic [31:0] payload);
        @(negedge ccip_clk);
        rpc_in.flow_id = flow;
        rpc_in.payload = payload;
        rpc_req        = 1'b1;
    endtask

    task automatic send_request(input logic [2:0] flow, input logic [31:0] payload);
        bit got;
        int cycles;
        raise_request(flow, payload);
        wait_for_ack(20, got, cycles);
        assert (got) else report_failure("no rpc_ack for a request");
        assert (!got || cycles == 1) else report_failure("rpc_ack came later than one cycle");
        if (got) begin
            record_request(flow, payload);
        end
        release_request();
    endtask

    task automatic send_random(input int count);
        logic [31:0] rnd;
        logic [31:0] payload;
        for (int n = 0; n < count; n++) begin
            rnd     = $random(seed);
            payload = $random(seed);
            send_request(rnd[2:0], payload);
        end
    endtask

    task automatic wait_for_drain(input int limit);
        int i;
        i = 0;
        while (exp_q.size() != 0 && i < limit) begin
            @(negedge ccip_clk);
            i++;
        end
        assert (exp_q.size() == 0) else report_failure("expected packets never came out");
        // Let the sent counter catch up with the last packet
        repeat (2) @(negedge ccip_clk);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_start_errors) begin
            $display("Test %0d %s: PASS", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: FAIL with %0d errors", tests_run, name,
                     errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        logic [63:0] rd;
        logic [63:0] sent_before;
        bit          got;
        int          ack_cycles;
        logic [7:0]  sels [4];

        seed              = 22938;
        errors            = 0;
        tests_run         = 0;
        tests_failed      = 0;
        test_start_errors = 0;
        model_flows       = 8;
        model_accepted    = '0;
        model_dropped     = '0;
        model_sent        = '0;
        for (int f = 0; f < 8; f++) begin
            model_seq[f] = '0;
        end
        ccip_clk = 1'b0;
        reset    = 1'b1;
        mmio     = '0;
        rpc_req  = 1'b0;
        rpc_in   = '0;

        repeat (2) @(posedge ccip_clk);
        @(negedge ccip_clk);
        reset = 1'b0;

        // Reset values
        compare_value("rpc_ack", 64'd0, 64'(rpc_ack));
        compare_value("net_tx_valid", 64'd0, 64'(net_tx_valid));
        compare_value("mmio_rsp.rd_valid", 64'd0, 64'(mmio_rsp.rd_valid));
        csr_read(nic_pkg::addr_nic_status, rd);
        compare_value("status", {54'd0, 8'd5, 1'b0, 1'b0}, rd);
        csr_read(nic_pkg::addr_ccip_mode, rd);
        compare_value("ccip_mode", 64'd3, rd);
        finish_test("reset values");

        // Random traffic over all 8 flows
        csr_write(nic_pkg::addr_num_flows, 64'd8);
        csr_write(nic_pkg::addr_nic_start, 64'd1);
        send_random(60);
        wait_for_drain(200);
        finish_test("random traffic");

        // Flows 3 and above are dropped
        csr_write(nic_pkg::addr_num_flows, 64'd3);
        model_flows = 3;
        send_random(30);
        wait_for_drain(200);
        finish_test("flow check");

        // Queue fills while stopped and the ninth request is held off
        csr_write(nic_pkg::addr_num_flows, 64'd8);
        model_flows = 8;
        csr_write(nic_pkg::addr_nic_start, 64'd0);
        sent_before = model_sent;
        send_random(8);
        csr_read(nic_pkg::addr_nic_status, rd);
        compare_value("status", {54'd0, 8'd5, 1'b0, 1'b1}, rd);
        raise_request(3'd6, 32'hcafe_0009);
        wait_for_ack(50, got, ack_cycles);
        assert (!got) else report_failure("ninth request was acked while the queue was full");
        csr_write(nic_pkg::addr_nic_start, 64'd1);
        wait_for_ack(50, got, ack_cycles);
        assert (got) else report_failure("ninth request never acked after start");
        if (got) begin
            record_request(3'd6, 32'hcafe_0009);
        end
        release_request();
        wait_for_drain(100);
        compare_value("packets after start", 64'd9, model_sent - sent_before);
        finish_test("back-pressure");

        // Packet counters and the unused selector 5
        sels[0] = 8'd0;
        sels[1] = 8'd1;
        sels[2] = 8'd2;
        sels[3] = 8'd5;
        for (int s = 0; s < 4; s++) begin
            csr_write(nic_pkg::addr_get_pck_cnt, 64'(sels[s]));
            csr_read(nic_pkg::addr_pck_cnt, rd);
            case (s)
                0: compare_value("pck_cnt accepted", model_accepted, rd);
                1: compare_value("pck_cnt dropped", model_dropped, rd);
                2: compare_value("pck_cnt sent", model_sent, rd);
                default: compare_value("pck_cnt unused", 64'd0, rd);
            endcase
        end
        finish_test("counters");

        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: nic.f
src/nic_pkg.sv
src/nic_csr.sv
src/rpc_ingress.sv
src/rpc_fifo.sv
src/net_tx_builder.sv
src/nic.sv
tb/nic_tb.sv

// File: Bender.yml
package:
  name: nic

sources:
  - src/nic_pkg.sv
  - src/nic_csr.sv
  - src/rpc_ingress.sv
  - src/rpc_fifo.sv
  - src/net_tx_builder.sv
  - src/nic.sv
  - target: simulation
    files:
      - tb/nic_tb.sv
